// File: sim/sifhPatterns.txt
# t <name> | r <timestamp> <repeat> <idle cycles after each> | d <timestamp>
# c <pixel> <peak bin> <peak count>, numbers in hex, 32 samples per pixel
t single_peak
r 52 0c 01
r a7 08 00
r 13 06 02
r f0 06 00
c 0 5 0c
t tie_bins_3_9
r 9f 0a 01
r 30 0a 00
r 64 06 02
r c1 06 00
c 1 3 0a
t one_bin_full
r 7c 20 00
c 2 7 20
t back_to_back
r 48 0c 00
r e0 01 00
r e1 01 00
r 48 01 00
r 2a 11 00
d 2a
c 3 2 11
t wrap_and_drop
r 0f 04 02
r b3 08 01
r 5a 08 00
r d0 0c 01
d d0
d d1
c 0 d 0c

// File: project.f
design/sifhPkg.sv
design/histBus.sv
design/histRam.sv
design/acqSequencer.sv
design/histAccumulator.sv
design/peakScanner.sv
design/sifhTop.sv
sim/sifhProperties.sv
sim/sifhTb.sv

// File: Makefile
TOP = sifhTb
OBJ = obj_dir

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir $(OBJ) -o $(TOP)

run: build
	./$(OBJ)/$(TOP) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

lint:
	verilator --lint-only --timing --assert -Wall -f project.f --top-module $(TOP)

clean:
	rm -rf $(OBJ) sim.log

.PHONY: all build run lint clean

// File: sim/sifhTb.sv
module sifhTb
    import sifhPkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_FRAMES = 6;
    // five directed pixels from the pattern file, then the random frames
    localparam int TOTAL_PIXELS = 5 + RANDOM_FRAMES;
    localparam int WATCHDOG_CYCLES = TOTAL_PIXELS * (SAMPLES_PER_PIXEL * 4 + 100);

    logic clk;
    logic arstN;
    logic [TS_WIDTH-1:0] timestamp;
    logic timestampValid;
    logic wrEn;
    logic peakValid;
    logic [PIXEL_BITS-1:0] peakPixel;
    logic [BIN_BITS-1:0] peakBin;
    logic [COUNT_WIDTH-1:0] peakCount;

    // reference histogram of the samples the DUT should have taken
    int modelHist [BIN_NUM];
    // {pixel, bin, count} per result pulse
    logic [PIXEL_BITS+BIN_BITS+COUNT_WIDTH-1:0] resultQ [$];
    int expPixel;
    int errorCount;
    int testCount;
    int testFails;
    logic [31:0] lcgState;

    sifhTop dut0 (
        .clk(clk),
        .arstN(arstN),
        .timestamp(timestamp),
        .timestampValid(timestampValid),
        .wrEn(wrEn),
        .peakValid(peakValid),
        .peakPixel(peakPixel),
        .peakBin(peakBin),
        .peakCount(peakCount)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // result pulse, stable at the falling edge
    always @(negedge clk) begin
        if (peakValid) begin
            resultQ.push_back({peakPixel, peakBin, peakCount});
        end
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("TIMEOUT: run still busy after %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic checkValue(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errorCount++;
        end
    endtask

    // one idle cycle, valid low
    task automatic nextCycle();
        @(posedge clk);
        #DRIVE_DELAY;
        timestampValid = 1'b0;
    endtask

    task automatic driveIdle(input int cycles);
        repeat (cycles) begin
            nextCycle();
        end
    endtask

    task automatic driveSample(input logic [TS_WIDTH-1:0] ts);
        @(posedge clk);
        #DRIVE_DELAY;
        timestamp = ts;
        timestampValid = 1'b1;
        // taken at the next edge only if wrEn is high now
        if (wrEn && modelHist[ts[TS_WIDTH-1 -: BIN_BITS]] < int'(COUNT_MAX)) begin
            modelHist[ts[TS_WIDTH-1 -: BIN_BITS]]++;
        end
    endtask

    task automatic waitWrEn(input logic level);
        while (wrEn !== level) begin
            nextCycle();
        end
    endtask

    task automatic checkResult(input string name, input bit fromFile,
                               input int filePixel, input int fileBin, input int fileCount);
        logic [PIXEL_BITS-1:0] gotPixel;
        logic [BIN_BITS-1:0] gotBin;
        logic [COUNT_WIDTH-1:0] gotCount;
        int bestBin;
        int bestCount;
        int taken;
        int errorsBefore;
        errorsBefore = errorCount;
        while (resultQ.size() == 0) begin
            nextCycle();
        end
        {gotPixel, gotBin, gotCount} = resultQ.pop_front();
        // highest count, lowest bin on a tie
        bestBin = 0;
        bestCount = modelHist[0];
        for (int b = 1; b < BIN_NUM; b++) begin
            if (modelHist[b] > bestCount) begin
                bestBin = b;
                bestCount = modelHist[b];
            end
        end
        // wrEn must close after exactly the quota
        taken = 0;
        foreach (modelHist[b]) begin
            taken += modelHist[b];
        end
        checkValue({name, " samples taken"}, taken, SAMPLES_PER_PIXEL);
        checkValue({name, " peakPixel"}, int'(gotPixel), expPixel);
        checkValue({name, " peakBin"}, int'(gotBin), bestBin);
        checkValue({name, " peakCount"}, int'(gotCount), bestCount);
        if (fromFile) begin
            checkValue({name, " pixel vs file"}, int'(gotPixel), filePixel);
            checkValue({name, " bin vs file"}, int'(gotBin), fileBin);
            checkValue({name, " count vs file"}, int'(gotCount), fileCount);
        end
        // next pixel starts from an empty histogram
        foreach (modelHist[b]) begin
            modelHist[b] = 0;
        end
        expPixel = (expPixel + 1) % PIXEL_NUM;
        testCount++;
        if (errorCount != errorsBefore) begin
            testFails++;
        end
        $display("test %0d %s: %s", testCount, name, (errorCount == errorsBefore) ? "ok" : "bad");
    endtask

    initial begin
        int fd;
        int rc;
        int a;
        int b;
        int c;
        int assertFails;
        string line;
        string tag;
        string testName;
        arstN = 1'b0;
        timestamp = '0;
        timestampValid = 1'b0;
        errorCount = 0;
        testCount = 0;
        testFails = 0;
        expPixel = 0;
        lcgState = 32'h832b571e;
        foreach (modelHist[i]) begin
            modelHist[i] = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arstN = 1'b1;
        // memory clear sweep runs first
        waitWrEn(1'b1);

        // directed pixels
        fd = $fopen("sim/sifhPatterns.txt", "r");
        if (fd == 0) begin
            $display("pattern file sim/sifhPatterns.txt could not be opened");
            errorCount++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                tag = "";
                rc = $fgets(line, fd);
                rc = $sscanf(line, "%s %h %h %h", tag, a, b, c);
                if (tag == "t") begin
                    rc = $sscanf(line, "%s %s", tag, testName);
                    waitWrEn(1'b1);
                end else if (tag == "r") begin
                    repeat (b) begin
                        driveSample(TS_WIDTH'(a));
                        driveIdle(c);
                    end
                end else if (tag == "d") begin
                    // stray strobe, must be dropped
                    waitWrEn(1'b0);
                    driveSample(TS_WIDTH'(a));
                    nextCycle();
                end else if (tag == "c") begin
                    checkResult(testName, 1'b1, a, b, c);
                end
            end
            $fclose(fd);
        end

        // random frames, fill until wrEn drops
        for (int f = 0; f < RANDOM_FRAMES; f++) begin
            waitWrEn(1'b1);
            while (wrEn) begin
                lcgState = lcgNext(lcgState);
                driveSample(lcgState[31:24]);
                driveIdle(int'(lcgState[23:22]) % 3);
            end
            checkResult($sformatf("random_frame_%0d", f), 1'b0, 0, 0, 0);
        end

        // any late pulse would be a spurious result
        driveIdle(BIN_NUM * 2);
        if (resultQ.size() != 0) begin
            $display("%0d peak results arrived that no test asked for", resultQ.size());
            errorCount++;
        end
        assertFails = dut0.sequencer.seqChecks.failCount
                    + dut0.accumulator.accChecks.failCount;
        if (assertFails != 0) begin
            $display("%0d assertion failures during the run", assertFails);
            errorCount += assertFails;
        end
        $display("tests %0d, failed %0d, errors %0d", testCount, testFails, errorCount);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: sim/sifhProperties.sv
module sifhPropertiesChecker
    import sifhPkg::*;
(
    input logic                   clk,
    input logic                   arstN,
    input seqStateT               state,
    input logic                   wrEn,
    input logic                   scanStart,
    input logic                   scanActive,
    input logic                   scanDone,
    input logic                   busy,
    input logic                   memWrite,
    input logic [COUNT_WIDTH-1:0] writeData,
    input logic [COUNT_WIDTH-1:0] readBase
);

    // assertion failures so far
    int failCount = 0;

    // accumulator stays off the memory while the scanner owns both ports
    assert property (@(posedge clk) disable iff (!arstN) scanActive |-> !busy)
        else begin
            $error("accumulator active during the scan phase");
            failCount++;
        end

    // no timestamps taken until the sweep reports done
    assert property (@(posedge clk) disable iff (!arstN)
                     (state == SCAN && !scanDone) |=> !wrEn)
        else begin
            $error("wrEn high before the scan finished");
            failCount++;
        end

    // sweep only starts with an empty pipe
    assert property (@(posedge clk) disable iff (!arstN) scanStart |-> !busy)
        else begin
            $error("scanStart while the accumulator is busy");
            failCount++;
        end

    // increment saturates, never wraps
    assert property (@(posedge clk) disable iff (!arstN) memWrite |-> (writeData >= readBase))
        else begin
            $error("bin count wrapped on write");
            failCount++;
        end

endmodule

bind acqSequencer sifhPropertiesChecker seqChecks (
    .clk(clk), .arstN(arstN), .state(state), .wrEn(wrEn),
    .scanStart(scanStart), .scanActive(scanActive), .scanDone(scanDone), .busy(busy),
    .memWrite(1'b0), .writeData('0), .readBase('0)
);

bind histAccumulator sifhPropertiesChecker accChecks (
    .clk(clk), .arstN(arstN), .state(sifhPkg::ACQUIRE), .wrEn(1'b0),
    .scanStart(1'b0), .scanActive(1'b0), .scanDone(1'b0), .busy(busy),
    .memWrite(s2Valid), .writeData(newCount), .readBase(baseCount)
);

// File: design/sifhTop.sv
module sifhTop
    import sifhPkg::*;
(
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [TS_WIDTH-1:0]    timestamp,
    input  logic                   timestampValid,
    output logic                   wrEn,
    output logic                   peakValid,
    output logic [PIXEL_BITS-1:0]  peakPixel,
    output logic [BIN_BITS-1:0]    peakBin,
    output logic [COUNT_WIDTH-1:0] peakCount
);

    logic sampleEnable;
    logic busy;
    logic scanStart;
    logic scanActive;
    logic scanDone;
    logic resultEnable;
    logic [PIXEL_BITS-1:0] pixelIdx;

    // one memory, two users
    histBus accBus ();
    histBus scanBus ();

    // strobes outside acquire are dropped
    assign sampleEnable = timestampValid && wrEn;

    acqSequencer sequencer (
        .clk(clk),
        .arstN(arstN),
        .timestampValid(timestampValid),
        .busy(busy),
        .scanDone(scanDone),
        .wrEn(wrEn),
        .scanStart(scanStart),
        .scanActive(scanActive),
        .resultEnable(resultEnable),
        .pixelIdx(pixelIdx),
        .state()
    );

    histAccumulator accumulator (
        .clk(clk),
        .arstN(arstN),
        .timestamp(timestamp),
        .sampleEnable(sampleEnable),
        .busy(busy),
        .mem(accBus)
    );

    peakScanner scanner (
        .clk(clk),
        .arstN(arstN),
        .scanStart(scanStart),
        .resultEnable(resultEnable),
        .pixelIdx(pixelIdx),
        .mem(scanBus),
        .scanDone(scanDone),
        .peakValid(peakValid),
        .peakPixel(peakPixel),
        .peakBin(peakBin),
        .peakCount(peakCount)
    );

    histRam ram (
        .clk(clk),
        .scanActive(scanActive),
        .accPort(accBus),
        .scanPort(scanBus)
    );

endmodule

// File: design/peakScanner.sv
module peakScanner
    import sifhPkg::*;
(
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   scanStart,
    input  logic                   resultEnable,
    input  logic [PIXEL_BITS-1:0]  pixelIdx,
    histBus.scan                   mem,
    output logic                   scanDone,
    output logic                   peakValid,
    output logic [PIXEL_BITS-1:0]  peakPixel,
    output logic [BIN_BITS-1:0]    peakBin,
    output logic [COUNT_WIDTH-1:0] peakCount
);

    // read sweep
    logic rdActive;
    logic [BIN_BITS-1:0] rdAddr;

    // compare stage, one cycle behind the read
    logic cmpValid;
    logic [BIN_BITS-1:0] cmpBin;
    logic lastCmp;
    logic takeNew;

    // running maximum
    logic [COUNT_WIDTH-1:0] maxCount;
    logic [BIN_BITS-1:0] maxBin;

    // strictly greater keeps the lowest bin on a tie
    assign takeNew = cmpValid && (mem.rdata > maxCount);
    assign lastCmp = cmpValid && (cmpBin == BIN_BITS'(BIN_NUM - 1));

    // sweep starts the cycle after scanStart
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdActive <= 1'b0;
            cmpValid <= 1'b0;
            scanDone <= 1'b0;
            peakValid <= 1'b0;
        end else begin
            if (scanStart) begin
                rdActive <= 1'b1;
            end else if (rdActive && (rdAddr == BIN_BITS'(BIN_NUM - 1))) begin
                rdActive <= 1'b0;
            end
            cmpValid <= rdActive;
            // result lands BIN_NUM + 2 after scanStart
            scanDone <= lastCmp;
            peakValid <= lastCmp && resultEnable;
        end
    end

    always_ff @(posedge clk) begin
        if (scanStart) begin
            rdAddr <= '0;
        end else if (rdActive) begin
            rdAddr <= rdAddr + 1'b1;
        end
        cmpBin <= rdAddr;
        if (scanStart) begin
            maxCount <= '0;
            maxBin <= '0;
        end else if (takeNew) begin
            maxCount <= mem.rdata;
            maxBin <= cmpBin;
        end
        // last bin may itself be the peak
        if (lastCmp) begin
            peakPixel <= pixelIdx;
            peakBin <= takeNew ? cmpBin : maxBin;
            peakCount <= takeNew ? mem.rdata : maxCount;
        end
    end

    assign mem.raddr = rdAddr;
    assign mem.rEnable = rdActive;

    // zero each bin once its count has been read
    assign mem.waddr = cmpBin;
    assign mem.wEnable = cmpValid;
    assign mem.wdata = '0;

endmodule

// File: design/histAccumulator.sv
module histAccumulator
    import sifhPkg::*;
(
    input  logic                clk,
    input  logic                arstN,
    input  logic [TS_WIDTH-1:0] timestamp,
    input  logic                sampleEnable,
    output logic                busy,
    histBus.accum               mem
);

    // stage one, bin from the timestamp MSBs
    logic [BIN_BITS-1:0] bin;

    // stage two, increment and write back
    logic s2Valid;
    logic [BIN_BITS-1:0] s2Bin;
    logic [COUNT_WIDTH-1:0] baseCount;
    logic [COUNT_WIDTH-1:0] newCount;

    // forwarding of the previous write
    logic fwdHit;
    logic [COUNT_WIDTH-1:0] fwdData;

    assign bin = timestamp[TS_WIDTH-1 -: BIN_BITS];

    // read is issued in the accept cycle
    assign mem.raddr = bin;
    assign mem.rEnable = sampleEnable;

    // control of the pipe
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            s2Valid <= 1'b0;
            fwdHit <= 1'b0;
        end else begin
            s2Valid <= sampleEnable;
            // this read misses the write happening now
            fwdHit <= sampleEnable && s2Valid && (bin == s2Bin);
        end
    end

    // payload
    always_ff @(posedge clk) begin
        s2Bin <= bin;
        fwdData <= newCount;
    end

    // stale read data is replaced by the value just written
    assign baseCount = fwdHit ? fwdData : mem.rdata;

    // hold at full scale instead of wrapping
    assign newCount = (baseCount == COUNT_MAX) ? baseCount : baseCount + 1'b1;

    // write one cycle after the read
    assign mem.waddr = s2Bin;
    assign mem.wEnable = s2Valid;
    assign mem.wdata = newCount;

    // in flight from accept until the write
    assign busy = sampleEnable || s2Valid;

endmodule

// File: design/acqSequencer.sv
module acqSequencer
    import sifhPkg::*;
(
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  timestampValid,
    input  logic                  busy,
    input  logic                  scanDone,
    output logic                  wrEn,
    output logic                  scanStart,
    output logic                  scanActive,
    output logic                  resultEnable,
    output logic [PIXEL_BITS-1:0] pixelIdx,
    output seqStateT              state
);

    // accepted samples of the current pixel
    logic [SAMPLE_CNT_BITS-1:0] sampleCount;
    logic accept;
    logic lastSample;
    // one-cycle kick for the clear sweep out of reset
    logic initStart;
    // high until the reset-time clear is done
    logic clearing;

    // timestamps only count while acquiring
    assign wrEn = (state == ACQUIRE);
    assign accept = timestampValid && wrEn;
    assign lastSample = (sampleCount == SAMPLE_CNT_BITS'(SAMPLES_PER_PIXEL - 1));

    // start the sweep once the last increment has landed
    assign scanStart = initStart || ((state == DRAIN) && !busy);
    assign scanActive = (state == SCAN);

    // no result for the clear sweep
    assign resultEnable = !clearing;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            // memory has no reset, so clear it with a silent scan first
            state <= SCAN;
            sampleCount <= '0;
            pixelIdx <= '0;
            initStart <= 1'b1;
            clearing <= 1'b1;
        end else begin
            initStart <= 1'b0;
            case (state)
                ACQUIRE: begin
                    if (accept) begin
                        if (lastSample) begin
                            // quota reached, wrEn drops next cycle
                            sampleCount <= '0;
                            state <= DRAIN;
                        end else begin
                            sampleCount <= sampleCount + 1'b1;
                        end
                    end
                end
                DRAIN: begin
                    if (!busy) begin
                        state <= SCAN;
                    end
                end
                SCAN: begin
                    if (scanDone) begin
                        state <= ACQUIRE;
                        clearing <= 1'b0;
                        // pixel index stays at 0 after the clear sweep
                        if (!clearing) begin
                            pixelIdx <= (pixelIdx == PIXEL_BITS'(PIXEL_NUM - 1)) ?
                                        '0 : pixelIdx + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ACQUIRE;
                end
            endcase
        end
    end

endmodule

// File: design/histRam.sv
module histRam
    import sifhPkg::*;
(
    input  logic clk,
    input  logic scanActive,
    histBus.ram  accPort,
    histBus.ram  scanPort
);

    // bin counts, one word per bin
    logic [COUNT_WIDTH-1:0] binMem [BIN_NUM];

    // selected port
    logic [BIN_BITS-1:0] raddr;
    logic rEnable;
    logic [BIN_BITS-1:0] waddr;
    logic wEnable;
    logic [COUNT_WIDTH-1:0] wdata;
    logic [COUNT_WIDTH-1:0] rdataQ;

    // scanner owns the memory during the scan phase
    // the sequencer keeps the two users apart
    always_comb begin
        if (scanActive) begin
            raddr = scanPort.raddr;
            rEnable = scanPort.rEnable;
            waddr = scanPort.waddr;
            wEnable = scanPort.wEnable;
            wdata = scanPort.wdata;
        end else begin
            raddr = accPort.raddr;
            rEnable = accPort.rEnable;
            waddr = accPort.waddr;
            wEnable = accPort.wEnable;
            wdata = accPort.wdata;
        end
    end

    // read returns the old word on a same-address write
    always_ff @(posedge clk) begin
        if (wEnable) begin
            binMem[waddr] <= wdata;
        end
        if (rEnable) begin
            rdataQ <= binMem[raddr];
        end
    end

    // both users see the same read register
    assign accPort.rdata = rdataQ;
    assign scanPort.rdata = rdataQ;

endmodule

// File: design/histBus.sv
interface histBus
    import sifhPkg::*;
();

    // read port, data one cycle after rEnable
    logic [BIN_BITS-1:0] raddr;
    logic rEnable;
    logic [COUNT_WIDTH-1:0] rdata;

    // write port
    logic [BIN_BITS-1:0] waddr;
    logic wEnable;
    logic [COUNT_WIDTH-1:0] wdata;

    // memory side
    modport ram (
        input  raddr, rEnable, waddr, wEnable, wdata,
        output rdata
    );

    // accumulator side, read-modify-write
    modport accum (
        output raddr, rEnable, waddr, wEnable, wdata,
        input  rdata
    );

    // scanner side, read then zero
    modport scan (
        output raddr, rEnable, waddr, wEnable, wdata,
        input  rdata
    );

endinterface

// File: design/sifhPkg.sv
package sifhPkg;

    // photon timestamp from the TDC
    localparam int TS_WIDTH = 8;

    // upper timestamp bits pick the bin
    localparam int BIN_BITS = 4;
    localparam int BIN_NUM = 1 << BIN_BITS;

    // per-bin count, saturating
    localparam int COUNT_WIDTH = 8;
    localparam logic [COUNT_WIDTH-1:0] COUNT_MAX = '1;

    // pixels sharing the one histogram memory
    localparam int PIXEL_NUM = 4;
    localparam int PIXEL_BITS = $clog2(PIXEL_NUM);

    // quota per pixel
    // acquisitions times samples in each acquisition
    localparam int ACQ_NUM = 4;
    localparam int DATA_NUM = 8;
    localparam int SAMPLES_PER_PIXEL = ACQ_NUM * DATA_NUM;
    localparam int SAMPLE_CNT_BITS = $clog2(SAMPLES_PER_PIXEL);

    // sequencer phases
    // ACQUIRE: timestamps accepted, wrEn high
    // DRAIN: last increment still in the pipe
    // SCAN: peak search and bin clear
    typedef enum logic [1:0] {
        ACQUIRE,
        DRAIN,
        SCAN
    } seqStateT;

endpackage
